// ==== vlog.f ====
+incdir+hdl
hdl/execLanePkg.sv
hdl/multAddUnit.sv
hdl/loadStoreUnit.sv
hdl/writeBackSelect.sv
hdl/execLane.sv
testbench/execLaneTb.sv

// ==== testbench/execLane_stimulus.txt ====
// gap opType opClass dst srcA srcB srcC kind expected (hex), one command per line
// kind 0 write-back with expected data, 1 store done, 2 stall for srcA cycles
0 0 0 01 3 5 7 0 16
0 0 0 02 a b 1 0 6f
0 0 0 03 10 10 5 0 105
0 3 0 04 4 0 2 0 13
0 3 1 05 8 0 1 0 1c
0 3 2 06 a abcd 0 1 0
0 3 0 07 5 0 5 0 abcd
2 3 3 08 14 1234 0 1 0
0 3 1 09 10 0 4 0 1234
0 3 0 0a 1 0 1 0 7
0 0 0 0b 2 3 4 0 a
0 0 0 0c ffffffff 2 3 0 1
0 0 0 0d 7 7 0 0 31
0 3 1 0e 0 0 3 0 a
0 0 0 00 8 0 0 2 0
0 0 0 0f 100 100 0 0 10000
3 3 0 10 30 0 f 0 be
0 0 0 11 0 0 0 0 0
0 0 0 12 12345 10 6 0 123456
0 3 2 13 20 5555 0 1 0
0 3 0 14 10 0 10 0 5555
0 0 0 00 5 0 0 2 0

// ==== testbench/execLaneTb.sv ====
// Execution lane testbench
// Issues commands from the stimulus file, models both memory ports and
// checks every write-back and done pulse against the expected table
`timescale 1ns/1ps
`default_nettype none
`include "execLane_settings.svh"

module execLaneTb;

	localparam int FIELDS = 9;
	localparam int MAX_LINES = 64;

	logic clock, reset, req, stall;
	execLanePkg::opTypeT opType;
	execLanePkg::opClassT opClass;
	execLanePkg::indexT dst;
	execLanePkg::issueNoT issueNo;
	execLanePkg::dataT srcA, srcB, srcC;
	logic memReady [2], memGrant [2], memEnd [2];
	execLanePkg::dataT loadData [2];
	wire memReqW [2], memWriteW [2], ldStDone [2];
	wire execLanePkg::dataT memAddrW [2], storeDataW [2];
	wire wbValid;
	wire execLanePkg::indexT wbDst;
	wire execLanePkg::dataT wbData;
	wire execLanePkg::issueNoT wbIssueNo;

	logic [31:0] stim [FIELDS*MAX_LINES];
	execLanePkg::dataT mem [2][64];			// Memory model, one array per port
	integer seed = 32'heb94_024a;
	int cycles = 0;
	int cycleLimit = 1000000;
	int pending = 0;
	int holdCount = 0;						// Edges where the multiply-add head waited
	logic expValid [256];
	logic [1:0] expKind [256];
	logic expMultAdd [256];
	execLanePkg::dataT expData [256];
	execLanePkg::indexT expDst [256];
	int reqCycle [256];
	int holdAtReq [256];
	logic unitBusy [2];
	logic loadReady [2];					// Load result waiting for write-back
	execLanePkg::issueNoT unitIssue [2];
	execLanePkg::issueNoT multAddOrder [$];	// Multiply-add issue order

	execLane dut (
		.clock(clock), .reset(reset), .req(req), .opType(opType), .opClass(opClass),
		.dst(dst), .issueNo(issueNo), .srcA(srcA), .srcB(srcB), .srcC(srcC), .stall(stall),
		.memReady0(memReady[0]), .memReady1(memReady[1]), .memGrant0(memGrant[0]),
		.memGrant1(memGrant[1]), .memEnd0(memEnd[0]), .memEnd1(memEnd[1]),
		.loadData0(loadData[0]), .loadData1(loadData[1]),
		.memReq0(memReqW[0]), .memReq1(memReqW[1]), .memWrite0(memWriteW[0]),
		.memWrite1(memWriteW[1]), .memAddr0(memAddrW[0]), .memAddr1(memAddrW[1]),
		.storeData0(storeDataW[0]), .storeData1(storeDataW[1]),
		.wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .wbIssueNo(wbIssueNo),
		.ldStDone0(ldStDone[0]), .ldStDone1(ldStDone[1])
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic fail(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input execLanePkg::dataT got,
			input execLanePkg::dataT exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			fail("wrong data value");
		end
	endtask

	task automatic checkIndex(input string name, input execLanePkg::indexT got,
			input execLanePkg::indexT exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			fail("wrong register index");
		end
	endtask

	task automatic checkIssue(input string name, input execLanePkg::issueNoT got,
			input execLanePkg::issueNoT exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			fail("wrong issue number");
		end
	endtask

	// Age of a result tag, wrapping with the issue number
	function automatic execLanePkg::issueNoT ageOf(input execLanePkg::issueNoT current,
			input execLanePkg::issueNoT tag);
		return current - tag;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory port model
	task automatic serveMemory(input int p);
		logic isWrite;
		execLanePkg::dataT addr, wdata;
		int delay;
		forever begin
			@(negedge clock);
			repeat ($unsigned($random(seed)) % 4) @(negedge clock);
			memReady[p] = 1'b1;
			do @(posedge clock); while (reset || !memReqW[p]);
			isWrite = memWriteW[p];
			addr = memAddrW[p];
			wdata = storeDataW[p];
			@(negedge clock);
			memReady[p] = 1'b0;
			memGrant[p] = 1'b1;
			delay = 1 + $unsigned($random(seed)) % 3;	// End one to three cycles on
			@(negedge clock);
			memGrant[p] = 1'b0;
			repeat (delay - 1) @(negedge clock);
			memEnd[p] = 1'b1;
			loadData[p] = mem[p][addr[5:0]];
			if (isWrite) mem[p][addr[5:0]] = wdata;
			@(negedge clock);
			memEnd[p] = 1'b0;
			loadData[p] = 'x;
		end
	endtask

	initial serveMemory(0);
	initial serveMemory(1);

	////////////////////////////////////////////////////////////////////////////
	// Result monitor
	always @(posedge clock) begin
		execLanePkg::issueNoT idx;
		execLanePkg::issueNoT bestIssue;
		logic bestValid;
		logic bestIsMultAdd;
		logic multAddReady;
		cycles <= cycles + 1;
		if (cycles > cycleLimit) fail("timeout: results did not arrive in time");
		if (!reset) begin
			// Oldest ready result wins the write-back port
			bestValid = 1'b0;
			bestIssue = '0;
			if (multAddOrder.size() != 0) begin
				idx = multAddOrder[0];
				bestValid = cycles >= reqCycle[idx] + `MULT_ADD_DEPTH
					+ holdCount - holdAtReq[idx];		// Head stage reached after holds
				bestIssue = idx;
			end
			multAddReady = bestValid;
			bestIsMultAdd = bestValid;
			for (int p = 1; p >= 0; p--) begin
				if (loadReady[p] && (!bestValid
						|| ageOf(issueNo, unitIssue[p]) > ageOf(issueNo, bestIssue))) begin
					bestValid = 1'b1;
					bestIssue = unitIssue[p];
					bestIsMultAdd = 1'b0;
				end
			end
			if (stall && wbValid) fail("write-back while stall is high");
			if (!stall && wbValid !== bestValid) begin
				if (bestValid)
					fail($sformatf("ready result of issue %0d not written back", bestIssue));
				else
					fail("write-back with no result ready");
			end
			if (multAddReady && (stall || !bestIsMultAdd)) holdCount++;
			if (wbValid) begin
				idx = wbIssueNo;
				if (!expValid[idx] || expKind[idx] != 2'd0)
					fail($sformatf("unexpected write-back for issue %0d", idx));
				checkIssue("wbIssueNo", wbIssueNo, bestIssue);
				checkIndex("wbDst", wbDst, expDst[idx]);
				checkData("wbData", wbData, expData[idx]);
				if (expMultAdd[idx]) checkIssue("wbIssueNo", wbIssueNo, multAddOrder.pop_front());
				expValid[idx] = 1'b0;
				pending--;
			end
			for (int p = 0; p < 2; p++) begin
				if (memEnd[p] && unitBusy[p] && expKind[unitIssue[p]] == 2'd0)
					loadReady[p] = 1'b1;					// Offered from the next cycle
				if (ldStDone[p]) begin
					idx = unitIssue[p];
					if (!unitBusy[p]) fail($sformatf("done pulse from idle unit %0d", p));
					if (expKind[idx] == 2'd1) begin
						if (!expValid[idx]) fail($sformatf("second done for issue %0d", idx));
						expValid[idx] = 1'b0;
						pending--;
					end else begin
						if (!wbValid) fail("load done without a write-back");
						checkIssue("wbIssueNo", wbIssueNo, idx);
						loadReady[p] = 1'b0;
					end
					unitBusy[p] = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	initial begin
		int lines;
		int b;
		int unit;
		{req, stall, opType, opClass, dst, issueNo} = '0;
		{srcA, srcB, srcC} = '0;
		for (int p = 0; p < 2; p++) begin
			{memReady[p], memGrant[p], memEnd[p]} = 3'b000;
			loadData[p] = '0;
			unitBusy[p] = 1'b0;
			loadReady[p] = 1'b0;
			unitIssue[p] = '0;
			for (int a = 0; a < 64; a++) mem[p][a] = a * 3 + 1;
		end
		for (int i = 0; i < 256; i++) expValid[i] = 1'b0;
		$readmemh("testbench/execLane_stimulus.txt", stim);
		lines = 0;
		while (lines < MAX_LINES && !$isunknown(stim[lines*FIELDS])) lines++;
		if (lines == 0) fail("stimulus file is empty or missing");
		cycleLimit = 60 * lines + 10;
		reset = 1'b1;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int n = 0; n < lines; n++) begin
			b = n * FIELDS;
			repeat (stim[b]) @(negedge clock);
			if (stim[b+7] == 2) begin
				stall = 1'b1;						// Hold write-back for srcA cycles
				repeat (stim[b+4]) @(negedge clock);
				stall = 1'b0;
			end else begin
				unit = stim[b+2][0];
				#1;
				if (stim[b+1][1:0] == execLanePkg::OP_MULT_ADD)
					while (dut.multAdd.hold) begin
						@(negedge clock);
						#1;
					end
				else
					while (unitBusy[unit]) @(negedge clock);
				{opType, opClass, dst} = {stim[b+1][1:0], stim[b+2][1:0], stim[b+3][4:0]};
				{srcA, srcB, srcC} = {stim[b+4], stim[b+5], stim[b+6]};
				expValid[issueNo] = 1'b1;
				expKind[issueNo] = stim[b+7][1:0];
				expData[issueNo] = stim[b+8];
				expDst[issueNo] = dst;
				expMultAdd[issueNo] = (opType == execLanePkg::OP_MULT_ADD);
				reqCycle[issueNo] = cycles;
				holdAtReq[issueNo] = holdCount;
				if (opType == execLanePkg::OP_MULT_ADD) multAddOrder.push_back(issueNo);
				else begin
					unitBusy[unit] = 1'b1;
					unitIssue[unit] = issueNo;
				end
				pending++;
				req = 1'b1;
				@(negedge clock);
				req = 1'b0;
				issueNo = issueNo + 1'b1;
			end
		end
		while (pending != 0) @(negedge clock);
		repeat (5) @(negedge clock);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/execLane.sv ====
// Vector execution lane
// Decodes commands into one multiply-add pipeline and two load/store units
// and merges their results onto one write-back port
`timescale 1ns/1ps
`default_nettype none

module execLane (
	input wire							clock,
	input wire							reset,
	input wire							req,
	input wire execLanePkg::opTypeT		opType,
	input wire execLanePkg::opClassT	opClass,
	input wire execLanePkg::indexT		dst,
	input wire execLanePkg::issueNoT	issueNo,		// Current issue number
	input wire execLanePkg::dataT		srcA,
	input wire execLanePkg::dataT		srcB,
	input wire execLanePkg::dataT		srcC,
	input wire							stall,			// Holds the write-back port
	input wire							memReady0,
	input wire							memReady1,
	input wire							memGrant0,
	input wire							memGrant1,
	input wire							memEnd0,
	input wire							memEnd1,
	input wire execLanePkg::dataT		loadData0,
	input wire execLanePkg::dataT		loadData1,
	output logic						memReq0,
	output logic						memReq1,
	output logic						memWrite0,
	output logic						memWrite1,
	output execLanePkg::dataT			memAddr0,
	output execLanePkg::dataT			memAddr1,
	output execLanePkg::dataT			storeData0,
	output execLanePkg::dataT			storeData1,
	output logic						wbValid,
	output execLanePkg::indexT			wbDst,
	output execLanePkg::dataT			wbData,
	output execLanePkg::issueNoT		wbIssueNo,
	output logic						ldStDone0,
	output logic						ldStDone1
);

	logic					multAddReq, evenReq, oddReq, isStore;
	logic					multAddValid, oddValid, evenValid;
	logic					multAddAccept, oddAccept, evenAccept;
	execLanePkg::indexT		multAddDst, oddDst, evenDst;
	execLanePkg::dataT		multAddData, oddData, evenData;
	execLanePkg::issueNoT	multAddIssueNo, oddIssueNo, evenIssueNo;

	////////////////////////////////////////////////////////////////////////////
	// Command decode
	assign multAddReq	= req & (opType == execLanePkg::OP_MULT_ADD);
	assign evenReq		= req & (opType == execLanePkg::OP_LOAD_STORE)
							& ~opClass[execLanePkg::CLASS_ODD_BIT];
	assign oddReq		= req & (opType == execLanePkg::OP_LOAD_STORE)
							& opClass[execLanePkg::CLASS_ODD_BIT];
	assign isStore		= opClass[execLanePkg::CLASS_STORE_BIT];

	multAddUnit multAdd (
		.clock(clock), .reset(reset), .req(multAddReq), .dst(dst), .issueNo(issueNo),
		.srcA(srcA), .srcB(srcB), .srcC(srcC), .accept(multAddAccept),
		.valid(multAddValid), .resDst(multAddDst), .resData(multAddData),
		.resIssueNo(multAddIssueNo)
	);

	loadStoreUnit ldStEven (
		.clock(clock), .reset(reset), .req(evenReq), .isStore(isStore), .dst(dst),
		.issueNo(issueNo), .srcA(srcA), .srcB(srcB), .srcC(srcC),
		.memReady(memReady0), .memGrant(memGrant0), .memEnd(memEnd0), .loadData(loadData0),
		.accept(evenAccept), .memReq(memReq0), .memWrite(memWrite0), .memAddr(memAddr0),
		.storeData(storeData0), .valid(evenValid), .resDst(evenDst), .resData(evenData),
		.resIssueNo(evenIssueNo), .done(ldStDone0)
	);

	loadStoreUnit ldStOdd (
		.clock(clock), .reset(reset), .req(oddReq), .isStore(isStore), .dst(dst),
		.issueNo(issueNo), .srcA(srcA), .srcB(srcB), .srcC(srcC),
		.memReady(memReady1), .memGrant(memGrant1), .memEnd(memEnd1), .loadData(loadData1),
		.accept(oddAccept), .memReq(memReq1), .memWrite(memWrite1), .memAddr(memAddr1),
		.storeData(storeData1), .valid(oddValid), .resDst(oddDst), .resData(oddData),
		.resIssueNo(oddIssueNo), .done(ldStDone1)
	);

	writeBackSelect wbSelect (
		.issueNo(issueNo), .stall(stall),
		.multAddValid(multAddValid), .multAddDst(multAddDst), .multAddData(multAddData),
		.multAddIssueNo(multAddIssueNo),
		.oddValid(oddValid), .oddDst(oddDst), .oddData(oddData), .oddIssueNo(oddIssueNo),
		.evenValid(evenValid), .evenDst(evenDst), .evenData(evenData),
		.evenIssueNo(evenIssueNo),
		.wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .wbIssueNo(wbIssueNo),
		.multAddAccept(multAddAccept), .oddAccept(oddAccept), .evenAccept(evenAccept)
	);

	// Every issued command must land in one of the units
	knownOpType: assert property (@(posedge clock) disable iff (reset)
		req |-> !$isunknown(opType) && (opType == execLanePkg::OP_MULT_ADD
			|| opType == execLanePkg::OP_LOAD_STORE))
		else $error("execLane: command with undefined opType");

endmodule

`default_nettype wire

// ==== hdl/writeBackSelect.sv ====
// Write-back select
// Picks the oldest offered result by issue-number age for the single write-back port
// Ties go to multiply-add, then the odd unit, then the even unit
`timescale 1ns/1ps
`default_nettype none

module writeBackSelect (
	input wire execLanePkg::issueNoT	issueNo,
	input wire							stall,
	input wire							multAddValid,
	input wire execLanePkg::indexT		multAddDst,
	input wire execLanePkg::dataT		multAddData,
	input wire execLanePkg::issueNoT	multAddIssueNo,
	input wire							oddValid,
	input wire execLanePkg::indexT		oddDst,
	input wire execLanePkg::dataT		oddData,
	input wire execLanePkg::issueNoT	oddIssueNo,
	input wire							evenValid,
	input wire execLanePkg::indexT		evenDst,
	input wire execLanePkg::dataT		evenData,
	input wire execLanePkg::issueNoT	evenIssueNo,
	output logic						wbValid,
	output execLanePkg::indexT			wbDst,
	output execLanePkg::dataT			wbData,
	output execLanePkg::issueNoT		wbIssueNo,
	output logic						multAddAccept,
	output logic						oddAccept,
	output logic						evenAccept
);

	execLanePkg::issueNoT	multAddAge;
	execLanePkg::issueNoT	oddAge;
	execLanePkg::issueNoT	evenAge;
	execLanePkg::issueNoT	ldStAge;
	logic					ldStValid;
	logic					oddFirst;
	logic					multAddFirst;

	// Age wraps with the issue number
	assign multAddAge	= issueNo - multAddIssueNo;
	assign oddAge		= issueNo - oddIssueNo;
	assign evenAge		= issueNo - evenIssueNo;

	assign oddFirst		= oddValid & (~evenValid | (oddAge >= evenAge));
	assign ldStValid	= oddValid | evenValid;
	assign ldStAge		= oddFirst ? oddAge : evenAge;
	assign multAddFirst	= multAddValid & (~ldStValid | (multAddAge >= ldStAge));

	assign wbValid			= (multAddValid | ldStValid) & ~stall;
	assign multAddAccept	= wbValid & multAddFirst;
	assign oddAccept		= wbValid & ~multAddFirst & oddFirst;
	assign evenAccept		= wbValid & ~multAddFirst & ~oddFirst;

	assign wbDst		= multAddFirst ? multAddDst : oddFirst ? oddDst : evenDst;
	assign wbData		= multAddFirst ? multAddData : oddFirst ? oddData : evenData;
	assign wbIssueNo	= multAddFirst ? multAddIssueNo : oddFirst ? oddIssueNo : evenIssueNo;

	// One accept per write-back, none under stall
	always_comb begin
		oneAccept: assert final ($onehot0({multAddAccept, oddAccept, evenAccept})
			&& (|{multAddAccept, oddAccept, evenAccept}) == wbValid)
			else $error("writeBackSelect: accept pulses disagree with wbValid");
	end

endmodule

`default_nettype wire

// ==== hdl/loadStoreUnit.sv ====
// Load/store unit
// Latches one command, runs the memory port handshake and holds the load
// result until the write-back port accepts it
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
	input wire							clock,
	input wire							reset,
	input wire							req,
	input wire							isStore,
	input wire execLanePkg::indexT		dst,
	input wire execLanePkg::issueNoT	issueNo,
	input wire execLanePkg::dataT		srcA,
	input wire execLanePkg::dataT		srcB,
	input wire execLanePkg::dataT		srcC,
	input wire							memReady,
	input wire							memGrant,
	input wire							memEnd,
	input wire execLanePkg::dataT		loadData,
	input wire							accept,
	output logic						memReq,
	output logic						memWrite,
	output execLanePkg::dataT			memAddr,
	output execLanePkg::dataT			storeData,
	output logic						valid,
	output execLanePkg::indexT			resDst,
	output execLanePkg::dataT			resData,
	output execLanePkg::issueNoT		resIssueNo,
	output logic						done
);

	execLanePkg::ldStStateT	state;
	logic					isStoreQ;				// Command kind of the latched access
	logic					storeDoneQ;				// Done pulse of a finished store

	////////////////////////////////////////////////////////////////////////////
	// FSM and memory request
	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= execLanePkg::IDLE;
			memReq		<= 1'b0;
			storeDoneQ	<= 1'b0;
		end else begin
			storeDoneQ	<= 1'b0;
			case (state)
				execLanePkg::IDLE: begin
					if (req) begin
						state <= execLanePkg::WAIT_READY;
					end
				end
				execLanePkg::WAIT_READY: begin
					if (memReq && memGrant) begin
						memReq	<= 1'b0;
						state	<= execLanePkg::ACCESS;
					end else if (memReady) begin
						memReq	<= 1'b1;			// Stays up until granted
					end
				end
				execLanePkg::ACCESS: begin
					if (memEnd) begin
						if (isStoreQ) begin
							storeDoneQ	<= 1'b1;
							state		<= execLanePkg::IDLE;
						end else begin
							state		<= execLanePkg::HOLD_RESULT;
						end
					end
				end
				execLanePkg::HOLD_RESULT: begin
					if (accept) begin
						state <= execLanePkg::IDLE;
					end
				end
				default: state <= execLanePkg::IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command and result registers
	always_ff @(posedge clock) begin
		if (state == execLanePkg::IDLE && req) begin
			isStoreQ	<= isStore;
			resDst		<= dst;
			resIssueNo	<= issueNo;
			memAddr		<= srcA + srcC;				// Base plus offset
			storeData	<= srcB;
		end
		if (state == execLanePkg::ACCESS && memEnd && !isStoreQ) begin
			resData		<= loadData;				// Valid in the end-of-access cycle
		end
	end

	assign memWrite	= memReq & isStoreQ;
	assign valid	= (state == execLanePkg::HOLD_RESULT);

	// A load is done once written back, a store right after its access
	assign done		= storeDoneQ | (valid & accept);

	reqWhileBusy: assert property (@(posedge clock) disable iff (reset)
		req |-> state == execLanePkg::IDLE)
		else $error("loadStoreUnit: request while busy");

endmodule

`default_nettype wire

// ==== hdl/multAddUnit.sv ====
// Multiply-add pipeline
// Stage 0 multiplies srcA by srcB, stage 1 adds srcC, later stages carry the result
// Every stage has its own valid bit, destination and issue number
`timescale 1ns/1ps
`default_nettype none
`include "execLane_settings.svh"

module multAddUnit (
	input wire							clock,
	input wire							reset,
	input wire							req,
	input wire execLanePkg::indexT		dst,
	input wire execLanePkg::issueNoT	issueNo,
	input wire execLanePkg::dataT		srcA,
	input wire execLanePkg::dataT		srcB,
	input wire execLanePkg::dataT		srcC,
	input wire							accept,
	output logic						valid,
	output execLanePkg::indexT			resDst,
	output execLanePkg::dataT			resData,
	output execLanePkg::issueNoT		resIssueNo
);

	logic					validQ		[`MULT_ADD_DEPTH];
	execLanePkg::indexT		dstQ		[`MULT_ADD_DEPTH];
	execLanePkg::issueNoT	issueQ		[`MULT_ADD_DEPTH];
	execLanePkg::dataT		dataQ		[`MULT_ADD_DEPTH];
	execLanePkg::dataT		addendQ;				// srcC on its way to the adder
	logic					hold;
	logic					advance;

	// Head result waiting for write-back freezes every stage
	assign hold		= validQ[`MULT_ADD_DEPTH-1] & ~accept;
	assign advance	= ~hold;

	////////////////////////////////////////////////////////////////////////////
	// Valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MULT_ADD_DEPTH; i++) begin
				validQ[i] <= 1'b0;
			end
		end else if (advance) begin
			validQ[0] <= req;
			for (int i = 1; i < `MULT_ADD_DEPTH; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data and tags
	always_ff @(posedge clock) begin
		if (advance) begin
			dstQ[0]		<= dst;
			issueQ[0]	<= issueNo;
			dataQ[0]	<= srcA * srcB;				// Low word of the product
			addendQ		<= srcC;
			dstQ[1]		<= dstQ[0];
			issueQ[1]	<= issueQ[0];
			dataQ[1]	<= dataQ[0] + addendQ;
			for (int i = 2; i < `MULT_ADD_DEPTH; i++) begin
				dstQ[i]		<= dstQ[i-1];
				issueQ[i]	<= issueQ[i-1];
				dataQ[i]	<= dataQ[i-1];
			end
		end
	end

	assign valid		= validQ[`MULT_ADD_DEPTH-1];
	assign resDst		= dstQ[`MULT_ADD_DEPTH-1];
	assign resData		= dataQ[`MULT_ADD_DEPTH-1];
	assign resIssueNo	= issueQ[`MULT_ADD_DEPTH-1];

	// Issue stage must not send a multiply-add into a frozen pipeline
	reqWhileHeld: assert property (@(posedge clock) disable iff (reset) req |-> !hold)
		else $error("multAddUnit: request while the pipeline holds");

endmodule

`default_nettype wire

// ==== hdl/execLanePkg.sv ====
// Execution lane package
// Shared word types, operation codes and the load/store FSM states
`default_nettype none
`include "execLane_settings.svh"

package execLanePkg;

	typedef logic [`DATA_WIDTH-1:0]		dataT;			// Data word
	typedef logic [`ISSUE_WIDTH-1:0]	issueNoT;		// Issue number tag
	typedef logic [`INDEX_WIDTH-1:0]	indexT;			// Register index

	typedef logic [1:0]					opTypeT;
	typedef logic [1:0]					opClassT;

	////////////////////////////////////////////////////////////////////////////
	// Operation type codes
	localparam opTypeT	OP_MULT_ADD		= 2'b00;
	localparam opTypeT	OP_LOAD_STORE	= 2'b11;

	// Bits of the operation class
	localparam int		CLASS_ODD_BIT	= 0;		// Odd load/store unit
	localparam int		CLASS_STORE_BIT	= 1;		// Store, not load

	////////////////////////////////////////////////////////////////////////////
	// Load/store unit FSM
	typedef enum logic [1:0] {
		IDLE,									// Free for a command
		WAIT_READY,								// Waiting for ready and grant
		ACCESS,									// Granted, waiting for end of access
		HOLD_RESULT								// Load data held until accepted
	} ldStStateT;

endpackage

`default_nettype wire

// ==== hdl/execLane_settings.svh ====
// Execution lane settings
// Data, issue-number and register-index widths, and the multiply-add depth
`ifndef EXEC_LANE_SETTINGS_SVH
`define EXEC_LANE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Word widths
`define DATA_WIDTH		32		// Operands and results
`define ISSUE_WIDTH		8		// Issue number tag, wraps around
`define INDEX_WIDTH		5		// Destination register index

////////////////////////////////////////////////////////////////////////////
// Pipeline
`define MULT_ADD_DEPTH	4		// Stages from request to offered result

`endif
